// File: design/shake_pkg.sv
/*
 * SHAKE engine shared definitions: Keccak widths, rates, padding words,
 * rho rotation table and the control and mode types.
 */
package shake_pkg;

  localparam int LANE_W        = 64;
  localparam int NUM_LANES     = 25;
  localparam int NUM_ROUNDS    = 24;
  localparam int RATE128_WORDS = 21; // 1344 bit rate
  localparam int RATE256_WORDS = 17; // 1088 bit rate
  localparam int BLK_CNT_W     = 9;

  typedef logic [LANE_W-1:0]               lane_t;
  typedef logic [NUM_LANES*LANE_W-1:0]     state_t;      // lane (x,y) at 5y+x
  typedef logic [RATE128_WORDS*LANE_W-1:0] rate_block_t;
  typedef logic [6:0]                      rc_t;         // bit j goes to 2^j-1
  typedef logic [4:0]                      round_t;
  typedef logic [4:0]                      word_idx_t;
  typedef logic [BLK_CNT_W-1:0]            blk_cnt_t;

  typedef enum logic {
    SHAKE128 = 1'b0,
    SHAKE256 = 1'b1
  } shake_mode_t;

  typedef enum logic [2:0] {
    IDLE,
    ABSORB,
    PERMUTE,
    SQUEEZE,
    NEXT
  } ctrl_state_t;

  localparam lane_t PAD_FIRST = 64'h0000_0000_0000_001F; // domain bits plus first pad bit
  localparam lane_t PAD_LAST  = 64'h8000_0000_0000_0000;

  // indexed by 5y+x
  localparam int RHO_OFFSETS [NUM_LANES] = '{
     0,  1, 62, 28, 27,
    36, 44,  6, 55, 20,
     3, 10, 43, 25, 39,
    41, 45, 15, 21,  8,
    18,  2, 61, 56, 14
  };

  // index of the last lane inside the rate
  function automatic word_idx_t rate_last(shake_mode_t mode);
    return (mode == SHAKE256) ? word_idx_t'(RATE256_WORDS - 1) : word_idx_t'(RATE128_WORDS - 1);
  endfunction

endpackage

// File: design/keccak_round.sv
/*
 * One Keccak-f[1600] round, purely combinational:
 * theta, rho, pi, chi and iota applied in sequence.
 */
`timescale 1ns/1ps

module keccak_round (
  input  shake_pkg::state_t i_state,
  input  shake_pkg::rc_t    i_rc,
  output shake_pkg::state_t o_state
);

  shake_pkg::lane_t a [shake_pkg::NUM_LANES];
  shake_pkg::lane_t c [5];
  shake_pkg::lane_t d [5];
  shake_pkg::lane_t t [shake_pkg::NUM_LANES];
  shake_pkg::lane_t b [shake_pkg::NUM_LANES];
  shake_pkg::lane_t e [shake_pkg::NUM_LANES];
  shake_pkg::lane_t rc_lane;

  function automatic shake_pkg::lane_t rotl(shake_pkg::lane_t v, int n);
    return (v << n) | (v >> ((shake_pkg::LANE_W - n) % shake_pkg::LANE_W));
  endfunction

  always_comb begin
    for (int i = 0; i < shake_pkg::NUM_LANES; i++) begin
      a[i] = i_state[i*shake_pkg::LANE_W +: shake_pkg::LANE_W];
    end
  end

  // theta
  always_comb begin
    for (int x = 0; x < 5; x++) begin
      c[x] = a[x] ^ a[x+5] ^ a[x+10] ^ a[x+15] ^ a[x+20]; // column parity
    end
    for (int x = 0; x < 5; x++) begin
      d[x] = c[(x+4)%5] ^ rotl(c[(x+1)%5], 1);
    end
    for (int i = 0; i < shake_pkg::NUM_LANES; i++) begin
      t[i] = a[i] ^ d[i%5];
    end
  end

  // rho and pi together: lane (x,y) moves to (y, 2x+3y)
  always_comb begin
    for (int x = 0; x < 5; x++) begin
      for (int y = 0; y < 5; y++) begin
        b[5*((2*x+3*y)%5) + y] = rotl(t[5*y+x], shake_pkg::RHO_OFFSETS[5*y+x]);
      end
    end
  end

  // chi
  always_comb begin
    for (int x = 0; x < 5; x++) begin
      for (int y = 0; y < 5; y++) begin
        e[5*y+x] = b[5*y+x] ^ (~b[5*y+(x+1)%5] & b[5*y+(x+2)%5]);
      end
    end
  end

  // iota, the 7 constant bits land on positions 2^j-1 of lane (0,0)
  always_comb begin
    rc_lane = '0;
    for (int j = 0; j < 7; j++) begin
      rc_lane[(1 << j) - 1] = i_rc[j];
    end
  end

  always_comb begin
    for (int i = 0; i < shake_pkg::NUM_LANES; i++) begin
      if (i == 0) begin
        o_state[i*shake_pkg::LANE_W +: shake_pkg::LANE_W] = e[i] ^ rc_lane;
      end else begin
        o_state[i*shake_pkg::LANE_W +: shake_pkg::LANE_W] = e[i];
      end
    end
  end

endmodule

// File: design/keccak_perm.sv
/*
 * Iterative Keccak-f[1600] permutation, one round per clock.
 * Round constants come from an 8-bit LFSR, the rate block is XORed in on start.
 */
`timescale 1ns/1ps

module keccak_perm (
  input  logic                   i_clk,
  input  logic                   i_rst_n,
  input  logic                   i_start,
  input  logic                   i_clear,
  input  logic                   i_absorb,
  input  shake_pkg::rate_block_t i_block,
  output logic                   o_done,
  output shake_pkg::state_t      o_state
);

  shake_pkg::state_t state_q;
  shake_pkg::state_t round_in;
  shake_pkg::state_t round_out;
  shake_pkg::round_t round_q;
  shake_pkg::rc_t    rc;
  logic [7:0]        lfsr_q;
  logic [7:0]        lfsr_d;
  logic              busy_q;
  logic              done_q;
  logic              last_round;

  assign last_round = busy_q && (round_q == shake_pkg::round_t'(shake_pkg::NUM_ROUNDS - 1));

  // round 0 runs in the start cycle itself
  assign round_in = (i_start && i_absorb) ? (state_q ^ shake_pkg::state_t'(i_block)) : state_q;

  // seven LFSR steps per round, output taken before each shift
  always_comb begin : rc_gen
    logic [7:0] r;
    r = i_start ? 8'h01 : lfsr_q;
    for (int j = 0; j < 7; j++) begin
      rc[j] = r[0];
      r = {r[6:0], 1'b0} ^ (8'h71 & {8{r[7]}}); // x^8+x^6+x^5+x^4+1
    end
    lfsr_d = r;
  end

  keccak_round u_round (
    .i_state (round_in),
    .i_rc    (rc),
    .o_state (round_out)
  );

  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      busy_q  <= 1'b0;
      done_q  <= 1'b0;
      round_q <= '0;
      lfsr_q  <= 8'h01;
    end else begin
      done_q <= last_round;
      if (i_start) begin
        busy_q  <= 1'b1;
        round_q <= shake_pkg::round_t'(1);
        lfsr_q  <= lfsr_d;
      end else if (busy_q) begin
        round_q <= round_q + 1'b1;
        lfsr_q  <= lfsr_d;
        if (last_round) begin
          busy_q <= 1'b0;
        end
      end
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_clear) begin
      state_q <= '0; // new command starts from the all-zero state
    end else if (i_start || busy_q) begin
      state_q <= round_out;
    end
  end

  assign o_done  = done_q;
  assign o_state = state_q;

endmodule

// File: design/shake_absorb.sv
/*
 * Message absorber: packs 64-bit words into a rate block and
 * appends the SHAKE padding after the last word.
 */
`timescale 1ns/1ps

module shake_absorb (
  input  logic                   i_clk,
  input  logic                   i_rst_n,
  input  logic                   i_arm,
  input  shake_pkg::shake_mode_t i_mode,
  input  logic                   i_in_valid,
  input  shake_pkg::lane_t       i_in_data,
  input  logic                   i_in_last,
  input  logic                   i_take,
  output logic                   o_in_ready,
  output logic                   o_block_valid,
  output shake_pkg::rate_block_t o_block,
  output logic                   o_block_final
);

  shake_pkg::rate_block_t buf_q;
  shake_pkg::word_idx_t   idx_q;
  shake_pkg::word_idx_t   last_idx;
  shake_pkg::lane_t       wr_data;
  logic armed_q;
  logic full_q;
  logic final_q;
  logic ended_q;     // last message word stored, only pad words follow
  logic pad_first_q;
  logic msg_wr;
  logic pad_wr;
  logic at_end;

  assign last_idx   = shake_pkg::rate_last(i_mode);
  assign at_end     = (idx_q == last_idx);
  assign o_in_ready = armed_q && !full_q && !ended_q;
  assign msg_wr     = o_in_ready && i_in_valid;
  assign pad_wr     = armed_q && !full_q && ended_q; // no handshake for pad words

  always_comb begin
    if (!ended_q) begin
      wr_data = i_in_data;
    end else begin
      wr_data = pad_first_q ? shake_pkg::PAD_FIRST : '0;
      if (at_end) begin
        wr_data = wr_data | shake_pkg::PAD_LAST;
      end
    end
  end

  always_ff @(posedge i_clk) begin
    if (msg_wr || pad_wr) begin
      buf_q[idx_q*shake_pkg::LANE_W +: shake_pkg::LANE_W] <= wr_data;
    end
  end

  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      armed_q     <= 1'b0;
      full_q      <= 1'b0;
      final_q     <= 1'b0;
      ended_q     <= 1'b0;
      pad_first_q <= 1'b0;
      idx_q       <= '0;
    end else if (i_arm) begin
      armed_q     <= 1'b1;
      full_q      <= 1'b0;
      final_q     <= 1'b0;
      ended_q     <= 1'b0;
      pad_first_q <= 1'b0;
      idx_q       <= '0;
    end else begin
      if (msg_wr || pad_wr) begin
        if (at_end) begin
          idx_q   <= '0;
          full_q  <= 1'b1;
          final_q <= ended_q; // a message word in the last lane leaves the pad for the next block
        end else begin
          idx_q <= idx_q + 1'b1;
        end
        if (msg_wr && i_in_last) begin
          ended_q     <= 1'b1;
          pad_first_q <= 1'b1;
        end else if (pad_wr) begin
          pad_first_q <= 1'b0;
        end
      end
      if (i_take && full_q) begin
        full_q <= 1'b0;
        if (final_q) begin
          armed_q <= 1'b0;
          ended_q <= 1'b0;
          final_q <= 1'b0;
        end
      end
    end
  end

  // lanes above the rate stay zero so the XOR leaves the capacity alone
  always_comb begin
    for (int i = 0; i < shake_pkg::RATE128_WORDS; i++) begin
      o_block[i*shake_pkg::LANE_W +: shake_pkg::LANE_W] =
        (i <= int'(last_idx)) ? buf_q[i*shake_pkg::LANE_W +: shake_pkg::LANE_W] : '0;
    end
  end

  assign o_block_valid = full_q;
  assign o_block_final = final_q;

endmodule

// File: design/shake_squeeze.sv
/*
 * Output squeezer: captures the rate lanes of the state and
 * streams them out lane 0 first under valid/ready.
 */
`timescale 1ns/1ps

module shake_squeeze (
  input  logic                   i_clk,
  input  logic                   i_rst_n,
  input  logic                   i_load,
  input  shake_pkg::shake_mode_t i_mode,
  input  shake_pkg::state_t      i_state,
  input  logic                   i_out_ready,
  output logic                   o_out_valid,
  output shake_pkg::lane_t       o_out_data,
  output logic                   o_block_done
);

  shake_pkg::rate_block_t buf_q;
  shake_pkg::word_idx_t   cnt_q;
  logic valid_q;
  logic xfer;
  logic last_word;

  assign xfer      = valid_q && i_out_ready;
  assign last_word = (cnt_q == shake_pkg::rate_last(i_mode));

  always_ff @(posedge i_clk) begin
    if (i_load) begin
      buf_q <= i_state[shake_pkg::RATE128_WORDS*shake_pkg::LANE_W-1:0];
    end else if (xfer) begin
      buf_q <= buf_q >> shake_pkg::LANE_W; // next lane moves to the bottom
    end
  end

  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      valid_q <= 1'b0;
      cnt_q   <= '0;
    end else if (i_load) begin
      valid_q <= 1'b1;
      cnt_q   <= '0;
    end else if (xfer) begin
      cnt_q <= cnt_q + 1'b1;
      if (last_word) begin
        valid_q <= 1'b0;
      end
    end
  end

  assign o_out_valid  = valid_q;
  assign o_out_data   = buf_q[shake_pkg::LANE_W-1:0];
  assign o_block_done = xfer && last_word;

endmodule

// File: design/shake_ctrl.sv
/*
 * Command FSM: accepts a command, alternates absorb and permute until the
 * padded block is in, then alternates squeeze and permute per output block.
 */
`timescale 1ns/1ps

module shake_ctrl (
  input  logic                   i_clk,
  input  logic                   i_rst_n,
  input  logic                   i_cmd_valid,
  input  shake_pkg::shake_mode_t i_cmd_mode,
  input  shake_pkg::blk_cnt_t    i_cmd_out_blocks,
  input  logic                   i_block_valid,
  input  logic                   i_block_final,
  input  logic                   i_perm_done,
  input  logic                   i_sq_block_done,
  output logic                   o_cmd_ready,
  output logic                   o_arm,
  output logic                   o_clear,
  output shake_pkg::shake_mode_t o_mode,
  output logic                   o_take,
  output logic                   o_perm_start,
  output logic                   o_perm_absorb,
  output logic                   o_sq_load
);

  shake_pkg::ctrl_state_t state_q;
  shake_pkg::shake_mode_t mode_q;
  shake_pkg::blk_cnt_t    blocks_q;    // output blocks still to load
  logic                   squeezing_q; // padded block has been taken
  logic                   accept;
  logic                   block_go;

  assign accept   = (state_q == shake_pkg::IDLE) && i_cmd_valid;
  assign block_go = (state_q == shake_pkg::ABSORB) && i_block_valid;

  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      state_q     <= shake_pkg::IDLE;
      mode_q      <= shake_pkg::SHAKE128;
      blocks_q    <= '0;
      squeezing_q <= 1'b0;
    end else begin
      case (state_q)
        shake_pkg::IDLE: if (i_cmd_valid) begin
          mode_q      <= i_cmd_mode;
          blocks_q    <= i_cmd_out_blocks;
          squeezing_q <= 1'b0;
          state_q     <= shake_pkg::ABSORB;
        end
        shake_pkg::ABSORB: if (i_block_valid) begin
          squeezing_q <= i_block_final;
          state_q     <= shake_pkg::PERMUTE;
        end
        shake_pkg::PERMUTE: if (i_perm_done) begin
          if (squeezing_q) begin
            blocks_q <= blocks_q - 1'b1;
            state_q  <= shake_pkg::SQUEEZE;
          end else begin
            state_q <= shake_pkg::ABSORB;
          end
        end
        shake_pkg::SQUEEZE: if (i_sq_block_done) begin
          state_q <= (blocks_q == '0) ? shake_pkg::IDLE : shake_pkg::NEXT;
        end
        shake_pkg::NEXT: state_q <= shake_pkg::PERMUTE;
        default: state_q <= shake_pkg::IDLE;
      endcase
    end
  end

  assign o_cmd_ready   = (state_q == shake_pkg::IDLE);
  assign o_arm         = accept;
  assign o_clear       = accept;
  assign o_mode        = mode_q;
  assign o_take        = block_go;
  assign o_perm_start  = block_go || (state_q == shake_pkg::NEXT);
  assign o_perm_absorb = (state_q == shake_pkg::ABSORB); // squeeze permutations add nothing
  assign o_sq_load     = (state_q == shake_pkg::PERMUTE) && i_perm_done && squeezing_q;

endmodule

// File: design/shake_top.sv
/*
 * SHAKE128/SHAKE256 engine top level: control FSM, absorber,
 * Keccak permutation and output squeezer.
 */
`timescale 1ns/1ps

module shake_top (
  input  logic                   i_clk,
  input  logic                   i_rst_n,
  input  logic                   i_cmd_valid,
  output logic                   o_cmd_ready,
  input  shake_pkg::shake_mode_t i_cmd_mode,
  input  shake_pkg::blk_cnt_t    i_cmd_out_blocks,
  input  logic                   i_in_valid,
  output logic                   o_in_ready,
  input  shake_pkg::lane_t       i_in_data,
  input  logic                   i_in_last,
  output logic                   o_out_valid,
  input  logic                   i_out_ready,
  output shake_pkg::lane_t       o_out_data
);

  shake_pkg::shake_mode_t mode;
  shake_pkg::rate_block_t block;
  shake_pkg::state_t      state;
  logic arm;
  logic clear;
  logic take;
  logic block_valid;
  logic block_final;
  logic perm_start;
  logic perm_absorb;
  logic perm_done;
  logic sq_load;
  logic sq_block_done;

  shake_ctrl u_ctrl (
    .i_clk            (i_clk),
    .i_rst_n          (i_rst_n),
    .i_cmd_valid      (i_cmd_valid),
    .i_cmd_mode       (i_cmd_mode),
    .i_cmd_out_blocks (i_cmd_out_blocks),
    .i_block_valid    (block_valid),
    .i_block_final    (block_final),
    .i_perm_done      (perm_done),
    .i_sq_block_done  (sq_block_done),
    .o_cmd_ready      (o_cmd_ready),
    .o_arm            (arm),
    .o_clear          (clear),
    .o_mode           (mode),
    .o_take           (take),
    .o_perm_start     (perm_start),
    .o_perm_absorb    (perm_absorb),
    .o_sq_load        (sq_load)
  );

  shake_absorb u_absorb (
    .i_clk         (i_clk),
    .i_rst_n       (i_rst_n),
    .i_arm         (arm),
    .i_mode        (mode),
    .i_in_valid    (i_in_valid),
    .i_in_data     (i_in_data),
    .i_in_last     (i_in_last),
    .i_take        (take),
    .o_in_ready    (o_in_ready),
    .o_block_valid (block_valid),
    .o_block       (block),
    .o_block_final (block_final)
  );

  keccak_perm u_perm (
    .i_clk    (i_clk),
    .i_rst_n  (i_rst_n),
    .i_start  (perm_start),
    .i_clear  (clear),
    .i_absorb (perm_absorb),
    .i_block  (block),
    .o_done   (perm_done),
    .o_state  (state)
  );

  shake_squeeze u_squeeze (
    .i_clk        (i_clk),
    .i_rst_n      (i_rst_n),
    .i_load       (sq_load),
    .i_mode       (mode),
    .i_state      (state),
    .i_out_ready  (i_out_ready),
    .o_out_valid  (o_out_valid),
    .o_out_data   (o_out_data),
    .o_block_done (sq_block_done)
  );

endmodule

// File: tb/tb_clock.sv
/* Testbench clock source, 20 ns period */
`timescale 1ns/1ps

module tb_clock (
  output logic o_clk
);

  initial begin
    o_clk = 1'b0;
  end

  always begin
    #10 o_clk = ~o_clk; // half period
  end

endmodule

// File: tb/shake_tb.sv
/*
 * SHAKE engine testbench: runs the stim file records through the DUT and
 * checks every output word against a FIPS 202 reference model.
 */
`timescale 1ns/1ps

module shake_tb;

  localparam int STIM_DEPTH   = 256;
  localparam int RESET_CYCLES = 10;

  logic                   clk;
  logic                   rst_n;
  logic                   cmd_valid;
  logic                   cmd_ready;
  shake_pkg::shake_mode_t cmd_mode;
  shake_pkg::blk_cnt_t    cmd_out_blocks;
  logic                   in_valid;
  logic                   in_ready;
  shake_pkg::lane_t       in_data;
  logic                   in_last;
  logic                   out_valid;
  logic                   out_ready;
  shake_pkg::lane_t       out_data;

  logic [63:0] stim_mem [0:STIM_DEPTH-1];
  logic [63:0] msg_q [$];
  logic [63:0] exp_q [$];
  logic [63:0] ks [5][5]; // reference state, lane (x,y)

  int errors;
  int words_checked;
  int timed_out;
  int cycles;
  int limit;

  tb_clock u_clock (
    .o_clk (clk)
  );

  shake_top u_shake_top (
    .i_clk            (clk),
    .i_rst_n          (rst_n),
    .i_cmd_valid      (cmd_valid),
    .o_cmd_ready      (cmd_ready),
    .i_cmd_mode       (cmd_mode),
    .i_cmd_out_blocks (cmd_out_blocks),
    .i_in_valid       (in_valid),
    .o_in_ready       (in_ready),
    .i_in_data        (in_data),
    .i_in_last        (in_last),
    .o_out_valid      (out_valid),
    .i_out_ready      (out_ready),
    .o_out_data       (out_data)
  );

  function automatic logic [63:0] rotl64(logic [63:0] v, int n);
    if (n == 0) begin
      return v;
    end
    return (v << n) | (v >> (64 - n));
  endfunction

  // round constant bit rc(t), straight from the LFSR definition in FIPS 202
  function automatic logic rc_bit(int t);
    logic [8:0] r;
    int m;
    m = t % 255;
    r = 9'b1;
    for (int i = 1; i <= m; i++) begin
      r = {r[7:0], 1'b0};
      r[0] = r[0] ^ r[8];
      r[4] = r[4] ^ r[8];
      r[5] = r[5] ^ r[8];
      r[6] = r[6] ^ r[8];
      r[8] = 1'b0;
    end
    return r[0];
  endfunction

  task automatic keccak_f();
    logic [63:0] c [5];
    logic [63:0] d [5];
    logic [63:0] b [5][5];
    logic [63:0] rc_lane;
    int x;
    int y;
    int nx;
    for (int ir = 0; ir < 24; ir++) begin
      for (int i = 0; i < 5; i++) begin
        c[i] = ks[i][0] ^ ks[i][1] ^ ks[i][2] ^ ks[i][3] ^ ks[i][4];
      end
      for (int i = 0; i < 5; i++) begin
        d[i] = c[(i + 4) % 5] ^ rotl64(c[(i + 1) % 5], 1);
      end
      for (int i = 0; i < 5; i++) begin
        for (int j = 0; j < 5; j++) begin
          ks[i][j] = ks[i][j] ^ d[i];
        end
      end
      // rho walks the (x,y) orbit starting at (1,0)
      b[0][0] = ks[0][0];
      x = 1;
      y = 0;
      for (int t = 0; t < 24; t++) begin
        b[x][y] = rotl64(ks[x][y], ((t + 1) * (t + 2) / 2) % 64);
        nx = y;
        y = (2 * x + 3 * y) % 5;
        x = nx;
      end
      for (int i = 0; i < 5; i++) begin
        for (int j = 0; j < 5; j++) begin
          ks[i][j] = b[(i + 3 * j) % 5][i]; // pi
        end
      end
      for (int i = 0; i < 5; i++) begin
        for (int j = 0; j < 5; j++) begin
          b[i][j] = ks[i][j] ^ (~ks[(i + 1) % 5][j] & ks[(i + 2) % 5][j]);
        end
      end
      for (int i = 0; i < 5; i++) begin
        for (int j = 0; j < 5; j++) begin
          ks[i][j] = b[i][j];
        end
      end
      rc_lane = '0;
      for (int j = 0; j < 7; j++) begin
        rc_lane[(1 << j) - 1] = rc_bit(j + 7 * ir);
      end
      ks[0][0] = ks[0][0] ^ rc_lane;
    end
  endtask

  // SHAKE of msg_q, fills exp_q with whole rate blocks covering out_words
  task automatic run_model(int mode, int out_words);
    logic [63:0] padded [$];
    int rate;
    int nblk;
    int lane;
    rate = (mode == 1) ? 17 : 21;
    for (int i = 0; i < 5; i++) begin
      for (int j = 0; j < 5; j++) begin
        ks[i][j] = '0;
      end
    end
    padded = msg_q;
    padded.push_back(64'h1f); // suffix 1111 and first pad bit in byte 0
    while (padded.size() % rate != 0) begin
      padded.push_back('0);
    end
    padded[padded.size() - 1] = padded[padded.size() - 1] | 64'h8000_0000_0000_0000;
    for (int i = 0; i < padded.size(); i++) begin
      lane = i % rate;
      ks[lane % 5][lane / 5] = ks[lane % 5][lane / 5] ^ padded[i];
      if (lane == rate - 1) begin
        keccak_f();
      end
    end
    exp_q.delete();
    nblk = (out_words + rate - 1) / rate;
    for (int blk = 0; blk < nblk; blk++) begin
      if (blk > 0) begin
        keccak_f();
      end
      for (int i = 0; i < rate; i++) begin
        exp_q.push_back(ks[i % 5][i / 5]);
      end
    end
  endtask

  task automatic load_message(int start, int n);
    msg_q.delete();
    for (int i = 0; i < n; i++) begin
      msg_q.push_back(stim_mem[start + i]);
    end
  endtask

  // words times 4 plus 30 cycles for each permutation
  function automatic int cycle_limit();
    int p;
    int kind;
    int rate;
    int blocks;
    int nwords;
    int total;
    p = 0;
    total = RESET_CYCLES + 20;
    kind = int'(stim_mem[0]);
    while (kind == 1 || kind == 2) begin
      if (kind == 1) begin
        p = p + 7 + int'(stim_mem[p + 2]);
      end else begin
        rate = (int'(stim_mem[p + 1]) == 1) ? 17 : 21;
        blocks = int'(stim_mem[p + 2]);
        nwords = int'(stim_mem[p + 4]);
        total = total + 4 * (nwords + blocks * rate) + 30 * (nwords / rate + blocks);
        p = p + 5 + nwords;
      end
      kind = int'(stim_mem[p]);
    end
    return total;
  endfunction

  task automatic check_word(int idx);
    words_checked++;
    assert (out_data === exp_q[idx]) else begin
      errors++;
      $display("ERROR t=%0t o_out_data word %0d expected %h got %h",
               $time, idx, exp_q[idx], out_data);
    end
  endtask

  task automatic send_message(bit stall);
    for (int i = 0; i < msg_q.size(); i++) begin
      in_valid = 1'b0;
      while (stall && ($urandom % 3 == 0)) begin
        @(negedge clk); // input gap
      end
      in_valid = 1'b1;
      in_data = msg_q[i];
      in_last = (i == msg_q.size() - 1);
      while (!in_ready) begin
        @(negedge clk);
      end
      @(negedge clk);
    end
    in_valid = 1'b0;
    in_last = 1'b0;
  endtask

  task automatic collect_output(bit stall);
    int got;
    got = 0;
    while (got < exp_q.size()) begin
      @(negedge clk);
      out_ready = stall ? ($urandom % 2 == 0) : 1'b1;
      if (out_valid && out_ready) begin
        check_word(got);
        got++;
      end
    end
  endtask

  // starts and ends on a falling edge
  task automatic run_command(int mode, int blocks, bit stall);
    cmd_valid = 1'b1;
    cmd_mode = (mode == 1) ? shake_pkg::SHAKE256 : shake_pkg::SHAKE128;
    cmd_out_blocks = shake_pkg::blk_cnt_t'(blocks);
    while (!cmd_ready) begin
      @(negedge clk);
    end
    @(negedge clk);
    cmd_valid = 1'b0;
    fork
      send_message(stall);
      collect_output(stall);
    join
    @(negedge clk);
    assert (cmd_ready === 1'b1) else begin
      errors++;
      $display("ERROR t=%0t o_cmd_ready expected 1 got %b", $time, cmd_ready);
    end
    assert (out_valid === 1'b0) else begin
      errors++;
      $display("ERROR t=%0t o_out_valid expected 0 got %b", $time, out_valid);
    end
  endtask

  task automatic check_reset_state();
    assert (cmd_ready === 1'b1) else begin
      errors++;
      $display("ERROR t=%0t o_cmd_ready expected 1 got %b", $time, cmd_ready);
    end
    assert (in_ready === 1'b0) else begin
      errors++;
      $display("ERROR t=%0t o_in_ready expected 0 got %b", $time, in_ready);
    end
    assert (out_valid === 1'b0) else begin
      errors++;
      $display("ERROR t=%0t o_out_valid expected 0 got %b", $time, out_valid);
    end
  endtask

  task automatic run_records();
    int p;
    int kind;
    int mode;
    int blocks;
    int stall;
    int nwords;
    int rate;
    int ncmd;
    p = 0;
    ncmd = 0;
    kind = int'(stim_mem[0]);
    while (kind == 1 || kind == 2) begin
      mode = int'(stim_mem[p + 1]);
      if (kind == 1) begin
        nwords = int'(stim_mem[p + 2]);
        load_message(p + 3, nwords);
        run_model(mode, 4);
        for (int i = 0; i < 4; i++) begin
          assert (exp_q[i] === stim_mem[p + 3 + nwords + i]) else begin
            errors++;
            $display("ERROR t=%0t reference model word %0d expected %h got %h",
                     $time, i, stim_mem[p + 3 + nwords + i], exp_q[i]);
          end
        end
        p = p + 7 + nwords;
      end else begin
        blocks = int'(stim_mem[p + 2]);
        stall = int'(stim_mem[p + 3]);
        nwords = int'(stim_mem[p + 4]);
        rate = (mode == 1) ? 17 : 21;
        load_message(p + 5, nwords);
        run_model(mode, blocks * rate);
        $display("command %0d: mode %0d, %0d message words, %0d blocks, stall %0d",
                 ncmd, mode, nwords, blocks, stall);
        run_command(mode, blocks, stall != 0);
        ncmd++;
        p = p + 5 + nwords;
      end
      kind = int'(stim_mem[p]);
    end
    if (kind != 0) begin
      errors++;
      $display("stim file has an unknown record kind %0d at word %0d", kind, p);
    end
    if (ncmd == 0) begin
      errors++;
      $display("stim file holds no commands");
    end
  endtask

  task automatic finish_run();
    $display("words checked %0d, errors %0d, timeouts %0d", words_checked, errors, timed_out);
    if (errors == 0 && timed_out == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  endtask

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (limit > 0 && cycles >= limit) begin
      $display("timeout: tests not finished after %0d cycles", cycles);
      timed_out = 1;
      finish_run();
    end
  end

  initial begin
    rst_n = 1'b0;
    cmd_valid = 1'b0;
    cmd_mode = shake_pkg::SHAKE128;
    cmd_out_blocks = '0;
    in_valid = 1'b0;
    in_data = '0;
    in_last = 1'b0;
    out_ready = 1'b0;
    errors = 0;
    words_checked = 0;
    timed_out = 0;
    cycles = 0;
    limit = 0;
    void'($urandom(32'h2bd219a5));
    $readmemh("tb/shake_stim.txt", stim_mem);
    limit = cycle_limit();
    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);
    check_reset_state();
    run_records();
    finish_run();
  end

endmodule

// File: verilog.f
design/shake_pkg.sv
design/keccak_round.sv
design/keccak_perm.sv
design/shake_absorb.sv
design/shake_squeeze.sv
design/shake_ctrl.sv
design/shake_top.sv
tb/tb_clock.sv
tb/shake_tb.sv

// File: Makefile
# Verilator build and run for the SHAKE engine testbench

VERILATOR ?= verilator
TOP       ?= shake_tb
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= Testbench passed

SOURCES := $(shell cat $(FILELIST))
BIN     := $(BUILD_DIR)/V$(TOP)

.PHONY: run build clean

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

build: $(BIN)

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)

// File: tb/shake_stim.txt
// kat record: 1 mode nwords, message words, then 4 reference output words
// cmd record: 2 mode out_blocks stall nwords, then message words
// mode 0 is SHAKE128 and 1 is SHAKE256, output words little-endian, 0 ends the file

// empty message known answers for the reference model
1 0 0
7d828fe8a42b9c7f 3e85057650456061 88bceff693803bd7 26ef66faac6e1aeb
1 1 0
138da80b2bddb946 24eb3e74eb3f3b23 821bb862ea52cd3f 2f76d56e64270cb5

// SHAKE128 short message, one block
2 0 1 0 3
0123456789abcdef fedcba9876543210 0f1e2d3c4b5a6978

// SHAKE256 34 words, ends on a block boundary, two blocks
2 1 2 0 22
6a09e667f3bcc908 bb67ae8584caa73b 3c6ef372fe94f82b a54ff53a5f1d36f1
510e527fade682d1 9b05688c2b3e6c1f 1f83d9abfb41bd6b 5be0cd19137e2179
428a2f98d728ae22 7137449123ef65cd b5c0fbcfec4d3b2f e9b5dba58189dbbc
3956c25bf348b538 59f111f1b605d019 923f82a4af194f9b ab1c5ed5da6d8118
d807aa98a3030242 12835b0145706fbe 243185be4ee4b28c 550c7dc3d5ffb4e2
72be5d74f27b896f 80deb1fe3b1696b1 9bdc06a725c71235 c19bf174cf692694
e49b69c19ef14ad2 efbe4786384f25e3 0fc19dc68b8cd5b5 240ca1cc77ac9c65
2de92c6f592b0275 4a7484aa6ea6e483 5cb0a9dcbd41fbd4 76f988da831153b5
983e5152ee66dfab a831c66d2db43210

// same vector with output stalls and input gaps
2 1 2 1 22
6a09e667f3bcc908 bb67ae8584caa73b 3c6ef372fe94f82b a54ff53a5f1d36f1
510e527fade682d1 9b05688c2b3e6c1f 1f83d9abfb41bd6b 5be0cd19137e2179
428a2f98d728ae22 7137449123ef65cd b5c0fbcfec4d3b2f e9b5dba58189dbbc
3956c25bf348b538 59f111f1b605d019 923f82a4af194f9b ab1c5ed5da6d8118
d807aa98a3030242 12835b0145706fbe 243185be4ee4b28c 550c7dc3d5ffb4e2
72be5d74f27b896f 80deb1fe3b1696b1 9bdc06a725c71235 c19bf174cf692694
e49b69c19ef14ad2 efbe4786384f25e3 0fc19dc68b8cd5b5 240ca1cc77ac9c65
2de92c6f592b0275 4a7484aa6ea6e483 5cb0a9dcbd41fbd4 76f988da831153b5
983e5152ee66dfab a831c66d2db43210

// back to back, SHAKE256 then SHAKE128
2 1 1 0 5
b00bfacecafe1234 0badc0dedeadbeef 1357924680aceb0d 55aa55aa33cc33cc
7766554433221100
2 0 2 0 7
8899aabbccddeeff 0011223344556677 f0e1d2c3b4a59687 1029384756afbecd
a1b2c3d4e5f60718 92a3b4c5d6e7f801 c0ffee00facade11

0
